// ==== Bender.yml ====
package:
  name: crc_apb

sources:
  - crc_pkg.sv
  - crc_slice_counter.sv
  - crc_lfsr.sv
  - crc_engine.sv
  - crc_result.sv
  - crc_apb_regs.sv
  - crc_apb_top.sv
  - target: test
    files:
      - crc_checker.sv
      - tb_crc_apb_top.sv

// ==== crc_apb_regs.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB slave for the CRC accelerator.
// register decode, read mux, clear and
// start generation, data write stall.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module crc_apb_regs
    import crc_pkg::*;
(
    input  logic        CLK,
    input  logic        reset,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    input  crc_status_t status,
    input  logic [CRC_WIDTH-1:0] result,
    output crc_word_t   word,
    output logic        clear
);

    logic access;
    logic hit_ctrl;
    logic hit_data;
    logic hit_result;
    logic hit_status;
    logic unmapped;
    logic ro_write;
    logic data_stall;
    logic done;
    logic start_q;
    logic [CRC_WIDTH-1:0] data_q;

    // ~~~~ decode ~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign access = apb_req.psel & apb_req.penable;
    assign hit_ctrl = (apb_req.paddr == REG_CTRL);
    assign hit_data = (apb_req.paddr == REG_DATA);
    assign hit_result = (apb_req.paddr == REG_RESULT);
    assign hit_status = (apb_req.paddr == REG_STATUS);
    assign unmapped = ~(hit_ctrl | hit_data | hit_result | hit_status);
    assign ro_write = apb_req.pwrite & (hit_result | hit_status);

    // a data word cannot be accepted until the engine has finished the last one.
    assign data_stall = access & apb_req.pwrite & hit_data & status.busy;
    assign done = access & ~data_stall;

    // ~~~~ response ~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        apb_rsp.pready = done;
        apb_rsp.pslverr = done & (unmapped | ro_write); // errors have no side effect.
        apb_rsp.prdata = '0;
        if (access && !apb_req.pwrite) begin
            if (hit_result) begin
                apb_rsp.prdata = result;
            end else if (hit_status) begin
                apb_rsp.prdata = {status.word_count, 15'd0, status.busy};
            end else if (hit_data) begin
                apb_rsp.prdata = data_q; // last word handed to the engine.
            end
        end
    end

    // ~~~~ control pulses ~~~~~~~~~~~~~~~~~~
    always_ff @(posedge CLK) begin
        if (reset) begin
            start_q <= 1'b0;
            clear <= 1'b0;
        end else begin
            start_q <= done & apb_req.pwrite & hit_data;
            clear <= done & apb_req.pwrite & hit_ctrl & apb_req.pwdata[0];
        end
    end

    // the word stays put while the engine walks its slices.
    always_ff @(posedge CLK) begin
        if (done && apb_req.pwrite && hit_data) begin
            data_q <= apb_req.pwdata;
        end
    end

    assign word = '{start: start_q, data: data_q};

    // an access phase always follows a setup phase of the same transfer.
    assert property (@(posedge CLK) disable iff (reset)
        apb_req.penable |-> apb_req.psel && $past(apb_req.psel))
        else $error("penable raised without a preceding setup phase");

endmodule

// ==== crc_apb_top.f ====
crc_pkg.sv
crc_slice_counter.sv
crc_lfsr.sv
crc_engine.sv
crc_result.sv
crc_apb_regs.sv
crc_apb_top.sv
crc_checker.sv
tb_crc_apb_top.sv

// ==== crc_apb_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level of the APB CRC accelerator.
// register block, engine and result.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module crc_apb_top
    import crc_pkg::*;
#(
    parameter logic [CRC_WIDTH-1:0] POLYNOMIAL = 32'h04C11DB7,
    parameter logic [CRC_WIDTH-1:0] INIT_VAL = '1,
    parameter logic [CRC_WIDTH-1:0] XOR_OUT = '1,
    parameter int UNROLL_FACTOR = 8
) (
    input  logic     CLK,
    input  logic     reset,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    crc_word_t word;
    crc_status_t status;
    logic clear;
    logic busy;
    logic word_done;
    logic [CRC_WIDTH-1:0] lfsr_state;
    logic [CRC_WIDTH-1:0] crc_value;
    logic [WORD_COUNT_WIDTH-1:0] word_count;

    assign status = '{busy: busy, word_count: word_count};

    crc_apb_regs u_regs (
        .CLK(CLK),
        .reset(reset),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp),
        .status(status),
        .result(crc_value),
        .word(word),
        .clear(clear)
    );

    crc_engine #(
        .UNROLL_FACTOR(UNROLL_FACTOR),
        .INIT_VAL(INIT_VAL),
        .POLYNOMIAL(POLYNOMIAL)
    ) u_engine (
        .CLK(CLK),
        .reset(reset),
        .clear(clear),
        .word(word),
        .busy(busy),
        .word_done(word_done),
        .lfsr_state(lfsr_state)
    );

    crc_result #(
        .XOR_OUT(XOR_OUT)
    ) u_result (
        .CLK(CLK),
        .reset(reset),
        .clear(clear),
        .lfsr_state(lfsr_state),
        .word_done(word_done),
        .crc_value(crc_value),
        .word_count(word_count)
    );

endmodule

// ==== crc_checker.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB monitor for the CRC testbench.
// pairs completed transfers with queued
// expectations and counts mismatches.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module crc_checker
    import crc_pkg::*;
(
    input  logic     CLK,
    input  logic     reset,
    input  apb_req_t apb_req,
    input  apb_rsp_t apb_rsp,
    output int       mismatches,
    output int       protocol_errors
);

    typedef struct packed {
        logic check_data;
        logic [CRC_WIDTH-1:0] data;
        logic slverr;
        logic stall;
    } expect_t;

    expect_t expect_q[$];
    logic stalled = 1'b0;
    int mismatch_count = 0;
    int protocol_count = 0;

    assign mismatches = mismatch_count;
    assign protocol_errors = protocol_count;

    // queued by the stimulus side before it starts the transfer.
    task automatic expect_transfer(
        input logic check_data,
        input logic [CRC_WIDTH-1:0] data,
        input logic slverr,
        input logic stall
    );
        expect_t entry;
        entry.check_data = check_data;
        entry.data = data;
        entry.slverr = slverr;
        entry.stall = stall;
        expect_q.push_back(entry);
    endtask

    function automatic int outstanding();
        return expect_q.size();
    endfunction

    // sampled on the falling edge, half a cycle away from any register update.
    always @(negedge CLK) begin : monitor
        expect_t want;
        if (reset) begin
            stalled = 1'b0;
        end else if (apb_req.psel && apb_req.penable && !apb_rsp.pready) begin
            stalled = 1'b1; // a wait state in this access phase.
        end else if (apb_req.psel && apb_req.penable) begin
            if (expect_q.size() == 0) begin
                $display("APB transfer to offset 0x%h at %0t completed with nothing expected",
                         apb_req.paddr, $time);
                protocol_count++;
            end else begin
                want = expect_q.pop_front();
                if (apb_rsp.pslverr !== want.slverr) begin
                    $display("ERR @%0t: offset 0x%h gave pslverr %b, expected %b",
                             $time, apb_req.paddr, apb_rsp.pslverr, want.slverr);
                    mismatch_count++;
                end
                if (stalled !== want.stall) begin
                    $display("ERR @%0t: offset 0x%h wait states seen %b, expected %b",
                             $time, apb_req.paddr, stalled, want.stall);
                    mismatch_count++;
                end
                if (want.check_data && !apb_req.pwrite && (apb_rsp.prdata !== want.data)) begin
                    $display("ERR @%0t: read of offset 0x%h returned 0x%08h, expected 0x%08h",
                             $time, apb_req.paddr, apb_rsp.prdata, want.data);
                    mismatch_count++;
                end
            end
            stalled = 1'b0;
        end
    end

endmodule

// ==== crc_engine.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CRC engine, slice sequencing around
// the unrolled LFSR.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module crc_engine
    import crc_pkg::*;
#(
    parameter int UNROLL_FACTOR = 8,
    parameter logic [CRC_WIDTH-1:0] INIT_VAL = '1,
    parameter logic [CRC_WIDTH-1:0] POLYNOMIAL = 32'h04C11DB7
) (
    input  logic        CLK,
    input  logic        reset,
    input  logic        clear,
    input  crc_word_t   word,
    output logic        busy,
    output logic        word_done,
    output logic [CRC_WIDTH-1:0] lfsr_state
);

    localparam int SLICES = CRC_WIDTH / UNROLL_FACTOR;
    localparam int CNT_W = (SLICES > 1) ? $clog2(SLICES) : 1;

    logic running;
    logic last;
    logic [CNT_W-1:0] count;
    logic [UNROLL_FACTOR-1:0] slice;

    if (CRC_WIDTH % UNROLL_FACTOR != 0) begin : g_bad_unroll
        $error("UNROLL_FACTOR must divide the CRC width");
    end

    // busy covers the start cycle itself, then the remaining slices.
    assign busy = word.start | running;
    assign word_done = busy & last;

    always_ff @(posedge CLK) begin
        if (reset || clear) begin
            running <= 1'b0;
        end else begin
            running <= busy & ~last; // drops after the terminal slice.
        end
    end

    if (SLICES == 1) begin : g_single
        // the whole word goes through in one step, no counter needed.
        assign count = '0;
        assign last = 1'b1;
    end else begin : g_multi
        crc_slice_counter #(
            .SLICES(SLICES)
        ) u_counter (
            .CLK(CLK),
            .reset(reset),
            .clear(clear),
            .count_enable(busy),
            .count(count),
            .last(last)
        );
    end

    assign slice = word.data[count*UNROLL_FACTOR +: UNROLL_FACTOR]; // low slice first.

    crc_lfsr #(
        .UNROLL_FACTOR(UNROLL_FACTOR),
        .INIT_VAL(INIT_VAL),
        .POLYNOMIAL(POLYNOMIAL)
    ) u_lfsr (
        .CLK(CLK),
        .reset(reset),
        .clear(clear),
        .enable(busy),
        .slice_in(slice),
        .state(lfsr_state)
    );

    // the register block must hold off new words until this one is absorbed.
    assert property (@(posedge CLK) disable iff (reset) word.start |-> !running)
        else $error("new word started while the engine was busy");

endmodule

// ==== crc_lfsr.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// left shifting Galois LFSR that takes
// UNROLL_FACTOR input bits per clock.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module crc_lfsr
    import crc_pkg::*;
#(
    parameter int UNROLL_FACTOR = 8,
    parameter logic [CRC_WIDTH-1:0] INIT_VAL = '1,
    parameter logic [CRC_WIDTH-1:0] POLYNOMIAL = 32'h04C11DB7
) (
    input  logic        CLK,
    input  logic        reset,
    input  logic        clear,
    input  logic        enable,
    input  logic [UNROLL_FACTOR-1:0] slice_in,
    output logic [CRC_WIDTH-1:0] state
);

    logic [CRC_WIDTH-1:0] next_state;

    // applies one serial step per input bit, bit 0 entering first.
    function automatic logic [CRC_WIDTH-1:0] absorb(
        input logic [CRC_WIDTH-1:0] cur,
        input logic [UNROLL_FACTOR-1:0] bits
    );
        logic [CRC_WIDTH-1:0] acc;
        logic feedback;
        acc = cur;
        for (int i = 0; i < UNROLL_FACTOR; i++) begin
            feedback = acc[CRC_WIDTH-1] ^ bits[i];
            acc = {acc[CRC_WIDTH-2:0], 1'b0};
            if (feedback) begin
                acc = acc ^ POLYNOMIAL; // taps of the generator.
            end
        end
        return acc;
    endfunction

    assign next_state = absorb(state, slice_in);

    always_ff @(posedge CLK) begin
        if (reset || clear) begin
            state <= INIT_VAL;
        end else if (enable) begin
            state <= next_state;
        end
    end

endmodule

// ==== crc_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the CRC accelerator.
// APB request/response, engine hand-off,
// status bundle and the register map.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package crc_pkg;

    // CRC and APB data width, one message word.
    localparam int CRC_WIDTH = 32;
    localparam int ADDR_WIDTH = 4;
    localparam int WORD_COUNT_WIDTH = 16;

    // ~~~~ register map ~~~~~~~~~~~~~~~~~~~~
    localparam logic [ADDR_WIDTH-1:0] REG_CTRL = 4'h0;   // bit 0 clears the CRC.
    localparam logic [ADDR_WIDTH-1:0] REG_DATA = 4'h4;   // message word input.
    localparam logic [ADDR_WIDTH-1:0] REG_RESULT = 4'h8; // read only.
    localparam logic [ADDR_WIDTH-1:0] REG_STATUS = 4'hC; // read only.

    // ~~~~ bus and hand-off types ~~~~~~~~~~
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] paddr;
        logic psel;
        logic penable;
        logic pwrite;
        logic [CRC_WIDTH-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [CRC_WIDTH-1:0] prdata;
        logic pready;
        logic pslverr;
    } apb_rsp_t;

    // start pulses for one cycle; data is held until the next word.
    typedef struct packed {
        logic start;
        logic [CRC_WIDTH-1:0] data;
    } crc_word_t;

    typedef struct packed {
        logic busy;
        logic [WORD_COUNT_WIDTH-1:0] word_count;
    } crc_status_t;

endpackage

// ==== crc_result.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output side. bit reversal, final XOR
// and the words absorbed counter.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module crc_result
    import crc_pkg::*;
#(
    parameter logic [CRC_WIDTH-1:0] XOR_OUT = '1
) (
    input  logic        CLK,
    input  logic        reset,
    input  logic        clear,
    input  logic [CRC_WIDTH-1:0] lfsr_state,
    input  logic        word_done,
    output logic [CRC_WIDTH-1:0] crc_value,
    output logic [WORD_COUNT_WIDTH-1:0] word_count
);

    function automatic logic [CRC_WIDTH-1:0] bit_reverse(
        input logic [CRC_WIDTH-1:0] value
    );
        logic [CRC_WIDTH-1:0] rev;
        for (int i = 0; i < CRC_WIDTH; i++) begin
            rev[i] = value[CRC_WIDTH-1-i];
        end
        return rev;
    endfunction

    // the register runs msb first, the reflected CRC reads it back to front.
    assign crc_value = bit_reverse(lfsr_state) ^ XOR_OUT;

    always_ff @(posedge CLK) begin
        if (reset || clear) begin
            word_count <= '0;
        end else if (word_done && (word_count != '1)) begin
            word_count <= word_count + 1'b1; // holds at the maximum.
        end
    end

endmodule

// ==== crc_slice_counter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wrapping slice counter with a
// terminal flag at SLICES minus 1.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module crc_slice_counter #(
    parameter int SLICES = 4,
    localparam int CNT_W = (SLICES > 1) ? $clog2(SLICES) : 1
) (
    input  logic             CLK,
    input  logic             reset,
    input  logic             clear,
    input  logic             count_enable,
    output logic [CNT_W-1:0] count,
    output logic             last
);

    localparam logic [CNT_W-1:0] LAST_VAL = CNT_W'(SLICES - 1);

    assign last = (count == LAST_VAL); // combinational, ends the word.

    always_ff @(posedge CLK) begin
        if (reset || clear) begin
            count <= '0;
        end else if (count_enable) begin
            if (last) begin
                count <= '0; // wrap for the next word.
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // a word that ends on its terminal slice leaves the counter at zero for the next one.
    assert property (@(posedge CLK) disable iff (reset) !count_enable |-> count == '0)
        else $error("slice counter idle away from the first slice");

endmodule

// ==== tb_crc_apb_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the APB CRC accelerator.
// clock, reset, APB driver, stimulus
// table, reference CRC and watchdog.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_crc_apb_top
    import crc_pkg::*;
();

    // reflected CRC-32 as software computes it, byte by byte, lsb first.
    localparam logic [CRC_WIDTH-1:0] REFLECTED_POLY = 32'hEDB88320;
    localparam logic [CRC_WIDTH-1:0] CRC_INIT = 32'hFFFFFFFF;
    localparam logic [CRC_WIDTH-1:0] FINAL_XOR = 32'hFFFFFFFF;
    localparam logic [CRC_WIDTH-1:0] RESIDUE = 32'h2144DF1C;
    localparam int ACCESS_LIMIT = 64;
    localparam int POLL_LIMIT = 16;

    typedef enum logic [2:0] {
        OP_WRITE, OP_WRITE_STALL, OP_WRITE_ERR, OP_READ, OP_READ_ERR, OP_WAIT_IDLE
    } op_t;

    typedef struct packed {
        op_t op;
        logic [ADDR_WIDTH-1:0] offset;
        logic [CRC_WIDTH-1:0] data;
        logic [CRC_WIDTH-1:0] expected;
    } row_t;

    logic CLK;
    logic reset;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    int mismatches;
    int protocol_errors;
    int run_errors = 0;
    int cycles = 0;
    int cycle_limit = 0;
    integer seed;
    logic aborted = 1'b0;
    row_t stim_table[$];

    crc_apb_top UUT (
        .CLK(CLK),
        .reset(reset),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp)
    );

    crc_checker u_checker (
        .CLK(CLK),
        .reset(reset),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp),
        .mismatches(mismatches),
        .protocol_errors(protocol_errors)
    );

    initial begin : clock_gen
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // ~~~~ reference model ~~~~~~~~~~~~~~~~
    function automatic logic [CRC_WIDTH-1:0] crc32_update(
        input logic [CRC_WIDTH-1:0] crc,
        input logic [CRC_WIDTH-1:0] word
    );
        logic [CRC_WIDTH-1:0] c;
        c = crc;
        for (int i = 0; i < CRC_WIDTH; i++) begin
            if (c[0] ^ word[i]) begin
                c = (c >> 1) ^ REFLECTED_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    task automatic add_row(input op_t op, input logic [ADDR_WIDTH-1:0] offset,
                           input logic [CRC_WIDTH-1:0] data, input logic [CRC_WIDTH-1:0] expected);
        row_t row;
        row = '{op: op, offset: offset, data: data, expected: expected};
        stim_table.push_back(row);
    endtask

    task automatic build_table();
        logic [CRC_WIDTH-1:0] ref_crc;
        logic [CRC_WIDTH-1:0] word;
        int count;
        ref_crc = CRC_INIT;
        count = 0;
        add_row(OP_READ, REG_STATUS, '0, '0); // idle state after reset.
        add_row(OP_READ, REG_RESULT, '0, ref_crc ^ FINAL_XOR);
        for (int i = 0; i < 4; i++) begin
            word = $random(seed);
            ref_crc = crc32_update(ref_crc, word);
            count++;
            add_row(OP_WRITE, REG_DATA, word, '0);
            add_row(OP_WAIT_IDLE, REG_STATUS, '0, '0);
            add_row(OP_READ, REG_RESULT, '0, ref_crc ^ FINAL_XOR);
        end
        add_row(OP_READ, REG_STATUS, '0, count << 16);
        word = ref_crc ^ FINAL_XOR; // the message CRC, appended as one more word.
        count++;
        add_row(OP_WRITE, REG_DATA, word, '0);
        add_row(OP_WAIT_IDLE, REG_STATUS, '0, '0);
        add_row(OP_READ, REG_RESULT, '0, RESIDUE);
        add_row(OP_READ, REG_STATUS, '0, count << 16);
        // ~~~~ clear, then back-to-back words ~~~~
        add_row(OP_WRITE, REG_CTRL, 32'h1, '0);
        ref_crc = CRC_INIT;
        count = 0;
        add_row(OP_READ, REG_STATUS, '0, '0);
        add_row(OP_READ, REG_RESULT, '0, ref_crc ^ FINAL_XOR);
        for (int i = 0; i < 3; i++) begin
            word = $random(seed);
            ref_crc = crc32_update(ref_crc, word);
            count++;
            add_row((i == 0) ? OP_WRITE : OP_WRITE_STALL, REG_DATA, word, '0);
        end
        add_row(OP_WAIT_IDLE, REG_STATUS, '0, '0);
        add_row(OP_READ, REG_RESULT, '0, ref_crc ^ FINAL_XOR);
        add_row(OP_READ, REG_STATUS, '0, count << 16);
        // ~~~~ error responses ~~~~~~~~~~~~~~~~
        add_row(OP_READ_ERR, 4'h2, '0, '0);
        add_row(OP_WRITE_ERR, 4'h6, 32'hDEADBEEF, '0);
        add_row(OP_WRITE_ERR, REG_RESULT, 32'h12345678, '0);
        add_row(OP_WRITE_ERR, REG_STATUS, 32'hFFFFFFFF, '0);
        add_row(OP_READ, REG_RESULT, '0, ref_crc ^ FINAL_XOR);
        add_row(OP_READ, REG_STATUS, '0, count << 16);
    endtask

    // ~~~~ APB driver ~~~~~~~~~~~~~~~~~~~~~
    // entered 1 ns after a rising edge and left at the same point.
    task automatic apb_transfer(input logic write, input logic [ADDR_WIDTH-1:0] addr,
                                input logic [CRC_WIDTH-1:0] wdata,
                                output logic [CRC_WIDTH-1:0] rdata, output logic ok);
        int waits;
        waits = 0;
        apb_req.paddr = addr;
        apb_req.pwrite = write;
        apb_req.pwdata = wdata;
        apb_req.psel = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge CLK);
        #1 apb_req.penable = 1'b1;
        @(negedge CLK);
        while (!apb_rsp.pready && waits < ACCESS_LIMIT) begin
            @(negedge CLK);
            waits++;
        end
        ok = apb_rsp.pready;
        rdata = apb_rsp.prdata;
        if (!ok) begin
            $display("APB access to offset 0x%h did not complete within %0d cycles",
                     addr, ACCESS_LIMIT);
            run_errors++;
        end
        @(posedge CLK);
        #1;
        apb_req.psel = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic wait_idle(output logic ok);
        logic [CRC_WIDTH-1:0] rdata;
        int polls;
        polls = 0;
        ok = 1'b1;
        rdata = 32'h1;
        while (ok && rdata[0] && polls < POLL_LIMIT) begin
            u_checker.expect_transfer(1'b0, '0, 1'b0, 1'b0);
            apb_transfer(1'b0, REG_STATUS, '0, rdata, ok);
            polls++;
        end
        if (ok && rdata[0]) begin
            $display("engine still busy after %0d status polls", polls);
            run_errors++;
            ok = 1'b0;
        end
    endtask

    task automatic run_row(input row_t row);
        logic [CRC_WIDTH-1:0] rdata;
        logic ok;
        logic is_write;
        logic is_err;
        if (row.op == OP_WAIT_IDLE) begin
            wait_idle(ok);
        end else begin
            is_write = (row.op == OP_WRITE) || (row.op == OP_WRITE_STALL) ||
                       (row.op == OP_WRITE_ERR);
            is_err = (row.op == OP_WRITE_ERR) || (row.op == OP_READ_ERR);
            u_checker.expect_transfer(row.op == OP_READ, row.expected, is_err,
                                      row.op == OP_WRITE_STALL);
            apb_transfer(is_write, row.offset, row.data, rdata, ok);
        end
        if (!ok) begin
            aborted = 1'b1;
        end
    endtask

    task automatic report_counts();
        $display("error counts: %0d mismatches, %0d protocol errors, %0d run errors",
                 mismatches, protocol_errors, run_errors);
    endtask

    // ~~~~ watchdog ~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("run stopped by the watchdog after %0d cycles", cycles);
        report_counts();
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : main
        seed = 53034;
        apb_req = '0;
        reset = 1'b1;
        build_table();
        cycle_limit = 20 * stim_table.size() + 200;
        repeat (10) @(posedge CLK);
        #1 reset = 1'b0;
        for (int i = 0; i < stim_table.size() && !aborted; i++) begin
            run_row(stim_table[i]);
        end
        if (u_checker.outstanding() != 0) begin
            $display("%0d expected transfers never completed", u_checker.outstanding());
            run_errors += u_checker.outstanding();
        end
        report_counts();
        if (mismatches + protocol_errors + run_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
